// File: Makefile
# Verilator build and run of the mmu testbench
TOP = mmu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
	verilator --binary --timing -f src.f --top-module $(TOP)

# pass only if the testbench printed the pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: bench/mmu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for mmu_top with tlb setup over apb
// both streams checked against a reference translation model on a shadow tlb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

module mmu_tb
    import mmu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    logic        clk = 1'b0;
    logic        rst_n_i;
    mmu_req_t    data_req, inst_req;
    mmu_resp_t   data_resp, inst_resp;
    logic        user_mode;
    logic [7:0]  asid;
    apb_req_t    apb_req;
    apb_resp_t   apb_resp;
    tlb_entry_t  shadow [`MMU_TLB_ENTRIES];   // what the tlb should hold
    logic [18:0] vpn_list [4];                // pages written in the translate test
    logic        apb_err;                     // pslverr of the last transfer
    logic [31:0] apb_rdata;
    string       test_name;
    integer      seed;
    integer      cycles = 0;
    integer      passes = 0;
    integer      fails = 0;
    integer      test_fails;

    mmu_top uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .data_req_i  (data_req),
        .inst_req_i  (inst_req),
        .data_resp_o (data_resp),
        .inst_resp_o (inst_resp),
        .user_mode_i (user_mode),
        .asid_i      (asid),
        .apb_req_i   (apb_req),
        .apb_resp_o  (apb_resp)
    );

    always #50 clk = ~clk;

    // limit is several times the ~220 cycles the tests need
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // returns -1 when no entry matches vpn2 with global or equal asid
    function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] id);
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (shadow[i].vpn2 == vpn2 && (shadow[i].g || shadow[i].asid == id)) begin
                return i;
            end
        end
        return -1;
    endfunction

    // reference translation from the segment and tlb rules
    function automatic mmu_resp_t expect_resp(input mmu_req_t req, input logic is_data);
        mmu_resp_t   r;
        logic [2:0]  seg;
        int          hit_i;
        tlb_entry_t  e;
        r          = '0;
        seg        = req.vaddr[31:29];
        r.uncached = (seg == 3'b101);                    // kseg1
        if (seg == 3'b100 || seg == 3'b101) begin
            r.paddr = {3'b000, req.vaddr[28:0]};
        end
        if (!req.en) return r;
        if (user_mode && req.vaddr[31]) begin
            r.illegal = 1'b1;
            return r;
        end
        if (seg == 3'b100 || seg == 3'b101) return r;    // unmapped so done
        hit_i = find_entry(req.vaddr[31:13], asid);
        if (hit_i < 0) begin
            r.miss = 1'b1;
            return r;
        end
        e = shadow[hit_i];
        if (req.vaddr[12]) begin                         // odd page
            r.paddr   = {e.pfn1, req.vaddr[11:0]};
            r.invalid = ~e.v1;
            r.modified = e.v1 & is_data & req.we & ~e.d1;
        end else begin
            r.paddr   = {e.pfn0, req.vaddr[11:0]};
            r.invalid = ~e.v0;
            r.modified = e.v0 & is_data & req.we & ~e.d0;
        end
        return r;
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic d,
                                            input logic v, input logic g);
        return {6'b0, pfn, 3'b0, d, v, g};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] want,
                                 input logic [31:0] got);
        if (got !== want) begin
            $display("Fail %s %s: expected %h actual %h", test_name, what, want, got);
            fails++;
            test_fails++;
        end else begin
            passes++;
        end
    endtask

    task automatic check_resp(input string port, input mmu_resp_t want,
                              input mmu_resp_t got, input logic en);
        compare_value({port, " flags"}, 32'(want[4:0]), 32'(got[4:0]));
        if (en && want[3:0] == 4'b0) begin               // paddr only without exception
            compare_value({port, " paddr"}, want.paddr, got.paddr);
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_fails = 0;
    endtask

    task automatic end_test();
        if (test_fails == 0) $display("test %s: ok", test_name);
        else $display("test %s: %0d errors", test_name, test_fails);
    endtask

    task automatic run_reset();
        @(posedge clk);
        #5;
        rst_n_i = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        rst_n_i = 1'b1;
    endtask

    task automatic set_mode(input logic user, input logic [7:0] id);
        @(posedge clk);
        #5;
        user_mode = user;
        asid      = id;
    endtask

    // setup cycle, access cycle, sample mid access, release after the edge
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #5;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(posedge clk);
        #5;
        apb_req.penable = 1'b1;
        @(negedge clk);
        compare_value("pready", 32'd1, 32'(apb_resp.pready));
        apb_err   = apb_resp.pslverr;
        apb_rdata = apb_resp.prdata;
        @(posedge clk);                                  // transfer completes here
        #5;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [7:0] addr);
        apb_xfer(1'b0, addr, 32'd0);
    endtask

    // TLBWI via the registers and mirrored into the shadow
    task automatic tlb_write(input logic [3:0] idx, input logic [18:0] vpn2,
                             input logic [31:0] lo0, input logic [31:0] lo1);
        apb_write(`MMU_REG_INDEX, 32'(idx));
        apb_write(`MMU_REG_ENTRYHI, {vpn2, 5'b0, asid});
        apb_write(`MMU_REG_ENTRYLO0, lo0);
        apb_write(`MMU_REG_ENTRYLO1, lo1);
        apb_write(`MMU_REG_COMMAND, `MMU_CMD_TLBWI);
        shadow[idx] = '{vpn2: vpn2, asid: asid, g: lo0[0] & lo1[0],
                        pfn0: lo0[25:6], d0: lo0[2], v0: lo0[1],
                        pfn1: lo1[25:6], d1: lo1[2], v1: lo1[1]};
    endtask

    // fetch requests carry we set which the dirty check must ignore
    task automatic translate_both(input logic [31:0] dva, input logic dwe,
                                  input logic [31:0] iva, input logic en);
        @(posedge clk);
        #5;
        data_req = '{vaddr: dva, en: en, we: dwe};
        inst_req = '{vaddr: iva, en: en, we: 1'b1};
        @(negedge clk);
        check_resp("data", expect_resp(data_req, 1'b1), data_resp, en);
        check_resp("inst", expect_resp(inst_req, 1'b0), inst_resp, en);
    endtask

    task automatic probe_entry(input logic [18:0] vpn2);
        int hit_i;
        apb_write(`MMU_REG_ENTRYHI, {vpn2, 5'b0, asid});
        apb_write(`MMU_REG_COMMAND, `MMU_CMD_TLBP);
        apb_read(`MMU_REG_INDEX);
        hit_i = find_entry(vpn2, asid);
        if (hit_i >= 0) compare_value("probe index", 32'(hit_i), apb_rdata);
        else compare_value("probe fail bit", 32'd1, 32'(apb_rdata[31]));
    endtask

    task automatic unmapped_segments();
        logic [31:0] va [4] = '{32'h8000_1234, 32'h9fff_fffc, 32'ha000_0010, 32'hbfc0_0180};
        start_test("unmapped");
        set_mode(1'b0, 8'h00);
        foreach (va[i]) translate_both(va[i], 1'b0, va[3-i], 1'b1);
        set_mode(1'b1, 8'h00);                           // user mode makes all illegal
        foreach (va[i]) translate_both(va[i], 1'b1, va[3-i], 1'b1);
        end_test();
    endtask

    task automatic register_access();
        logic [31:0] hi, lo0, lo1;
        start_test("registers");
        hi  = $random(seed) & 32'hffff_e0ff;             // only vpn2 and asid bits
        lo0 = $random(seed) & 32'h03ff_ffc7;
        lo1 = $random(seed) & 32'h03ff_ffc7;
        apb_write(`MMU_REG_ENTRYHI, hi);
        compare_value("write pslverr", 32'd0, 32'(apb_err));
        apb_write(`MMU_REG_ENTRYLO0, lo0);
        apb_write(`MMU_REG_ENTRYLO1, lo1);
        apb_write(`MMU_REG_INDEX, 32'd6);
        apb_write(8'h14, 32'hdead_beef);
        compare_value("bad offset write pslverr", 32'd1, 32'(apb_err));
        apb_read(8'h20);
        compare_value("bad offset read pslverr", 32'd1, 32'(apb_err));
        compare_value("bad offset read data", 32'd0, apb_rdata);
        apb_write(`MMU_REG_COMMAND, 32'd3);
        compare_value("bad command pslverr", 32'd1, 32'(apb_err));
        apb_read(`MMU_REG_ENTRYHI);
        compare_value("entryhi", hi, apb_rdata);
        apb_read(`MMU_REG_ENTRYLO0);
        compare_value("entrylo0", lo0, apb_rdata);
        apb_read(`MMU_REG_ENTRYLO1);
        compare_value("entrylo1", lo1, apb_rdata);
        apb_read(`MMU_REG_INDEX);
        compare_value("index", 32'd6, apb_rdata);
        end_test();
    endtask

    task automatic tlbwi_translate();
        logic [31:0] va0, va1;
        start_test("translate");
        set_mode(1'b0, 8'h21);
        for (int k = 0; k < 4; k++) begin
            vpn_list[k] = 19'($random(seed)) & 19'h3_ffff;    // kuseg pages
            tlb_write(4'(2 * k + 1), vpn_list[k], make_lo(20'($random(seed)), 1'b1, 1'b1, 1'b0),
                      make_lo(20'($random(seed)), 1'b1, 1'b1, 1'b0));
        end
        for (int k = 0; k < 4; k++) begin
            va0 = {vpn_list[k], 1'b0, 12'($random(seed))};
            va1 = {vpn_list[k], 1'b1, 12'($random(seed))};
            translate_both(va0, 1'b0, va1, 1'b1);
            translate_both(va1, 1'b1, va0, 1'b1);
        end
        set_mode(1'b0, 8'h33);                           // foreign asid misses
        translate_both({vpn_list[0], 13'h00a8}, 1'b0, {vpn_list[1], 13'h1ffc}, 1'b1);
        set_mode(1'b0, 8'h21);                           // entry keeps the old asid
        tlb_write(4'd1, vpn_list[0], make_lo(20'($random(seed)), 1'b1, 1'b1, 1'b1),
                  make_lo(20'($random(seed)), 1'b1, 1'b1, 1'b1));
        set_mode(1'b0, 8'h33);                           // only G can make this hit
        translate_both({vpn_list[0], 13'h00a8}, 1'b0, {vpn_list[0], 13'h1ffc}, 1'b1);
        end_test();
    endtask

    task automatic page_bits();
        start_test("page bits");
        set_mode(1'b0, 8'h21);
        // kseg2 pair with even page invalid and odd page valid but clean
        tlb_write(4'd9, 19'h6_1234, make_lo(20'h1_2345, 1'b1, 1'b0, 1'b0),
                  make_lo(20'h5_4321, 1'b0, 1'b1, 1'b0));
        translate_both({19'h6_1234, 13'h0010}, 1'b0, {19'h6_1234, 13'h0ff0}, 1'b1);
        translate_both({19'h6_1234, 13'h1010}, 1'b1, {19'h6_1234, 13'h1ff0}, 1'b1);
        translate_both({19'h6_1234, 13'h1010}, 1'b0, {19'h6_1234, 13'h1004}, 1'b1);
        end_test();
    endtask

    task automatic probe_lookup();
        start_test("probe");
        set_mode(1'b0, 8'h21);
        probe_entry(vpn_list[2]);
        probe_entry(19'h7_fffe);                         // never written
        probe_entry(vpn_list[0]);                        // global entry hit clears bit 31
        end_test();
    endtask

    task automatic reset_state();
        start_test("reset state");
        run_reset();
        foreach (shadow[i]) shadow[i] = '0;
        set_mode(1'b0, 8'h21);
        // both pages hit before the reset
        translate_both({vpn_list[0], 13'h0040}, 1'b0, {19'h6_1234, 13'h1ff0}, 1'b1);
        translate_both(32'h0000_0800, 1'b1, 32'hfff0_0000, 1'b1);   // vpn2 0 with another asid
        apb_read(`MMU_REG_INDEX);
        compare_value("index after reset", 32'd0, apb_rdata);
        set_mode(1'b1, 8'h00);                           // enable low raises nothing
        translate_both(32'h0000_0100, 1'b1, 32'h8000_0000, 1'b0);
        translate_both(32'hc000_0000, 1'b1, 32'ha000_0000, 1'b0);
        end_test();
    endtask

    initial begin
        rst_n_i   = 1'b0;
        data_req  = '0;
        inst_req  = '0;
        user_mode = 1'b0;
        asid      = 8'h00;
        apb_req   = '0;
        seed      = 32'hc4a25d89;
        foreach (shadow[i]) shadow[i] = '0;
        run_reset();
        unmapped_segments();
        register_access();
        tlbwi_translate();
        page_bits();
        probe_lookup();
        reset_state();
        $display("checks passed %0d failed %0d", passes, fails);
        if (fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/cp0_tlb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cp0 tlb registers behind an apb slave, no wait states
// writing COMMAND fires TLBWI or TLBP in the access cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

module cp0_tlb_regs
    import mmu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  apb_req_t                  apb_req_i,
    output apb_resp_t                 apb_resp_o,
    output logic                      tlb_wr_en_o,
    output logic [`MMU_TLB_IDX_W-1:0] tlb_wr_idx_o,
    output tlb_entry_t                tlb_wr_entry_o,
    output logic [31:0]               probe_vaddr_o,
    output logic [7:0]                probe_asid_o,
    input  tlb_result_t               probe_result_i
);

    logic [`MMU_TLB_IDX_W-1:0] index_q;
    logic                      probe_fail_q;   // INDEX[31], read only
    logic [18:0]               vpn2_q;
    logic [7:0]                asid_q;
    logic [22:0]               lo0_q;          // {pfn, d, v, g}
    logic [22:0]               lo1_q;
    logic                      access;         // apb access phase
    logic                      known_off;
    logic                      cmd_wr;
    logic                      cmd_ok;
    logic                      reg_wr;
    logic                      probe_stb;
    logic [31:0]               rdata;

    assign access    = apb_req_i.psel & apb_req_i.penable;
    assign known_off = apb_req_i.paddr inside {`MMU_REG_INDEX, `MMU_REG_ENTRYHI,
                       `MMU_REG_ENTRYLO0, `MMU_REG_ENTRYLO1, `MMU_REG_COMMAND};
    assign cmd_wr    = access & apb_req_i.pwrite & (apb_req_i.paddr == `MMU_REG_COMMAND);
    assign cmd_ok    = (apb_req_i.pwdata == `MMU_CMD_TLBWI) ||
                       (apb_req_i.pwdata == `MMU_CMD_TLBP);
    assign reg_wr    = access & apb_req_i.pwrite & known_off;
    assign probe_stb = cmd_wr & (apb_req_i.pwdata == `MMU_CMD_TLBP);

    assign tlb_wr_en_o  = cmd_wr & (apb_req_i.pwdata == `MMU_CMD_TLBWI);
    assign tlb_wr_idx_o = index_q;
    assign probe_vaddr_o = {vpn2_q, 13'b0};
    assign probe_asid_o  = asid_q;

    // entry image from the registers, G only if both halves say global
    always_comb begin
        tlb_wr_entry_o.vpn2 = vpn2_q;
        tlb_wr_entry_o.asid = asid_q;
        tlb_wr_entry_o.g    = lo0_q[0] & lo1_q[0];
        tlb_wr_entry_o.pfn0 = lo0_q[22:3];
        tlb_wr_entry_o.d0   = lo0_q[2];
        tlb_wr_entry_o.v0   = lo0_q[1];
        tlb_wr_entry_o.pfn1 = lo1_q[22:3];
        tlb_wr_entry_o.d1   = lo1_q[2];
        tlb_wr_entry_o.v1   = lo1_q[1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            index_q      <= '0;
            probe_fail_q <= 1'b0;
            vpn2_q       <= '0;
            asid_q       <= '0;
            lo0_q        <= '0;
            lo1_q        <= '0;
        end else begin
            if (reg_wr) begin
                case (apb_req_i.paddr)
                    `MMU_REG_INDEX:    index_q <= apb_req_i.pwdata[`MMU_TLB_IDX_W-1:0];
                    `MMU_REG_ENTRYHI: begin
                        vpn2_q <= apb_req_i.pwdata[31:13];
                        asid_q <= apb_req_i.pwdata[7:0];
                    end
                    `MMU_REG_ENTRYLO0: lo0_q <= {apb_req_i.pwdata[25:6], apb_req_i.pwdata[2:0]};
                    `MMU_REG_ENTRYLO1: lo1_q <= {apb_req_i.pwdata[25:6], apb_req_i.pwdata[2:0]};
                    default: ;                  // COMMAND handled by strobes
                endcase
            end
            if (probe_stb) begin
                probe_fail_q <= ~probe_result_i.hit;
                if (probe_result_i.hit) index_q <= probe_result_i.idx;  // miss keeps index
            end
        end
    end

    // read mux, COMMAND and holes read as zero
    always_comb begin
        case (apb_req_i.paddr)
            `MMU_REG_INDEX:    rdata = {probe_fail_q, 27'b0, index_q};
            `MMU_REG_ENTRYHI:  rdata = {vpn2_q, 5'b0, asid_q};
            `MMU_REG_ENTRYLO0: rdata = {6'b0, lo0_q[22:3], 3'b0, lo0_q[2:0]};
            `MMU_REG_ENTRYLO1: rdata = {6'b0, lo1_q[22:3], 3'b0, lo1_q[2:0]};
            default:           rdata = '0;
        endcase
    end

    assign apb_resp_o.prdata  = (access & ~apb_req_i.pwrite) ? rdata : '0;
    assign apb_resp_o.pready  = access;                         // never waits
    assign apb_resp_o.pslverr = access & (~known_off | (cmd_wr & ~cmd_ok));

endmodule

`default_nettype wire

// File: hdl/mem_map.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// segment decoder for one address stream, one instance per stream
// tells mapped vs direct, flags illegal kernel access and kseg1 uncached
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

module mem_map
    import mmu_pkg::*;
(
    input  mmu_req_t    req_i,
    input  logic        user_mode_i,
    output logic        using_tlb_o,   // kuseg or kseg2/3
    output logic        illegal_o,
    output logic        uncached_o,
    output logic [31:0] addr_o         // direct physical address
);

    logic [31:0] vaddr;
    logic        kernel_seg;           // anything at or above kseg0

    assign vaddr = req_i.vaddr;

    always_comb begin
        using_tlb_o = 1'b0;
        uncached_o  = 1'b0;
        kernel_seg  = 1'b0;
        addr_o      = '0;                 // zero when the tlb supplies it
        if (vaddr < `MMU_KSEG0_BASE) begin
            // kuseg, mapped and cached
            using_tlb_o = 1'b1;
        end else begin
            kernel_seg = 1'b1;
            if (vaddr < `MMU_KSEG1_BASE) begin
                addr_o = {3'b000, vaddr[28:0]};   // kseg0
            end else if (vaddr < `MMU_KSEG2_BASE) begin
                addr_o     = {3'b000, vaddr[28:0]};   // kseg1
                uncached_o = 1'b1;
            end else begin
                using_tlb_o = 1'b1;               // kseg2/kseg3
            end
        end
    end

    // user code may only touch kuseg
    assign illegal_o = req_i.en & user_mode_i & kernel_seg;

endmodule

`default_nettype wire

// File: hdl/mmu_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mmu constants: tlb geometry, segment bases, cp0 apb register map
// include wherever these names are used; guarded against double include
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// joint tlb
`define MMU_TLB_ENTRIES 16         // page-pair entries
`define MMU_TLB_IDX_W   4          // log2 of entry count
`define MMU_PAGE_SHIFT  12         // 4 KB pages only

// segment starts, everything below kseg0 is kuseg
`define MMU_KSEG0_BASE  32'h8000_0000  // unmapped, cached
`define MMU_KSEG1_BASE  32'hA000_0000  // unmapped, uncached
`define MMU_KSEG2_BASE  32'hC000_0000  // mapped, kernel only

// apb byte offsets of the cp0 tlb registers
`define MMU_REG_INDEX    8'h00
`define MMU_REG_ENTRYHI  8'h04
`define MMU_REG_ENTRYLO0 8'h08
`define MMU_REG_ENTRYLO1 8'h0C
`define MMU_REG_COMMAND  8'h10

// values written to COMMAND
`define MMU_CMD_TLBWI    32'd1     // write entry at INDEX
`define MMU_CMD_TLBP     32'd2     // probe for ENTRYHI

`endif

// File: hdl/mmu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the mmu: request/response, tlb entry, apb bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

    typedef struct packed {
        logic [31:0] vaddr;        // virtual address
        logic        en;           // access valid this cycle
        logic        we;           // store, data stream only
    } mmu_req_t;

    typedef struct packed {
        logic [31:0] paddr;        // valid only with no flag set
        logic        uncached;
        logic        illegal;      // kernel segment from user mode
        logic        miss;
        logic        invalid;
        logic        modified;     // store to clean page
    } mmu_resp_t;

    typedef struct packed {
        logic [18:0] vpn2;         // va[31:13]
        logic [7:0]  asid;
        logic        g;            // global, asid ignored
        logic [19:0] pfn0;         // even page
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;         // odd page
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic                        hit;
        logic [`MMU_TLB_IDX_W-1:0]   idx;   // lowest matching entry
        logic [19:0]                 pfn;   // of the page picked by va[12]
        logic                        d;
        logic                        v;
    } tlb_result_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

endpackage

`default_nettype wire

// File: hdl/mmu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mmu top: data and fetch translation in the same cycle, cp0 tlb via apb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

module mmu_top
    import mmu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  mmu_req_t    data_req_i,
    input  mmu_req_t    inst_req_i,
    output mmu_resp_t   data_resp_o,
    output mmu_resp_t   inst_resp_o,
    input  logic        user_mode_i,   // from cp0 status
    input  logic [7:0]  asid_i,        // running asid
    input  apb_req_t    apb_req_i,
    output apb_resp_t   apb_resp_o
);

    logic                      data_using_tlb, inst_using_tlb;
    logic                      data_illegal, inst_illegal;
    logic                      data_uncached, inst_uncached;
    logic [31:0]               data_direct, inst_direct;
    tlb_result_t               data_res, inst_res, probe_res;
    logic                      wr_en;
    logic [`MMU_TLB_IDX_W-1:0] wr_idx;
    tlb_entry_t                wr_entry;
    logic [31:0]               probe_vaddr;
    logic [7:0]                probe_asid;

    // merge segment decode and tlb answer, one flag at most
    // priority illegal > miss > invalid > modified
    function automatic mmu_resp_t resolve(input mmu_req_t req, input logic mapped,
                                          input logic illegal, input logic uncached,
                                          input logic [31:0] direct, input tlb_result_t res,
                                          input logic chk_mod);
        mmu_resp_t r;
        logic      tlb_use;
        tlb_use    = req.en & mapped & ~illegal;
        r.paddr    = mapped ? {res.pfn, req.vaddr[`MMU_PAGE_SHIFT-1:0]} : direct;
        r.uncached = uncached;
        r.illegal  = illegal;                            // already gated by en
        r.miss     = tlb_use & ~res.hit;
        r.invalid  = tlb_use & res.hit & ~res.v;
        r.modified = chk_mod & tlb_use & res.hit & res.v & req.we & ~res.d;
        return r;
    endfunction

    mem_map mem_map_data (
        .req_i       (data_req_i),
        .user_mode_i (user_mode_i),
        .using_tlb_o (data_using_tlb),
        .illegal_o   (data_illegal),
        .uncached_o  (data_uncached),
        .addr_o      (data_direct)
    );

    mem_map mem_map_inst (
        .req_i       (inst_req_i),
        .user_mode_i (user_mode_i),
        .using_tlb_o (inst_using_tlb),
        .illegal_o   (inst_illegal),
        .uncached_o  (inst_uncached),
        .addr_o      (inst_direct)
    );

    tlb_array tlb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wr_en_i        (wr_en),
        .wr_idx_i       (wr_idx),
        .wr_entry_i     (wr_entry),
        .probe_vaddr_i  (probe_vaddr),
        .probe_asid_i   (probe_asid),
        .probe_result_o (probe_res),
        .asid_i         (asid_i),
        .data_vaddr_i   (data_req_i.vaddr),
        .inst_vaddr_i   (inst_req_i.vaddr),
        .data_result_o  (data_res),
        .inst_result_o  (inst_res)
    );

    cp0_tlb_regs cp0_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .apb_req_i      (apb_req_i),
        .apb_resp_o     (apb_resp_o),
        .tlb_wr_en_o    (wr_en),
        .tlb_wr_idx_o   (wr_idx),
        .tlb_wr_entry_o (wr_entry),
        .probe_vaddr_o  (probe_vaddr),
        .probe_asid_o   (probe_asid),
        .probe_result_i (probe_res)
    );

    // fetches never write, dirty check on data only
    assign data_resp_o = resolve(data_req_i, data_using_tlb, data_illegal, data_uncached,
                                 data_direct, data_res, 1'b1);
    assign inst_resp_o = resolve(inst_req_i, inst_using_tlb, inst_illegal, inst_uncached,
                                 inst_direct, inst_res, 1'b0);

endmodule

`default_nettype wire

// File: hdl/tlb_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// joint tlb storage with one indexed write port and three lookups
// data, instruction and probe all see the same entry registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

module tlb_array
    import mmu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    // TLBWI
    input  logic                      wr_en_i,       // one-cycle strobe
    input  logic [`MMU_TLB_IDX_W-1:0] wr_idx_i,
    input  tlb_entry_t                wr_entry_i,
    // TLBP
    input  logic [31:0]               probe_vaddr_i,
    input  logic [7:0]                probe_asid_i,
    output tlb_result_t               probe_result_o,
    // translation streams
    input  logic [7:0]                asid_i,        // current asid
    input  logic [31:0]               data_vaddr_i,
    input  logic [31:0]               inst_vaddr_i,
    output tlb_result_t               data_result_o,
    output tlb_result_t               inst_result_o
);

    tlb_entry_t entries_q [`MMU_TLB_ENTRIES];

    // vpn2=0 and v=0 everywhere after reset, so nothing hits a valid page
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            entries_q[wr_idx_i] <= wr_entry_i;   // visible next cycle
        end
    end

    tlb_lookup lookup_data (
        .entries_i (entries_q),
        .vaddr_i   (data_vaddr_i),
        .asid_i    (asid_i),
        .result_o  (data_result_o)
    );

    tlb_lookup lookup_inst (
        .entries_i (entries_q),
        .vaddr_i   (inst_vaddr_i),
        .asid_i    (asid_i),
        .result_o  (inst_result_o)
    );

    // probe uses ENTRYHI's asid, not the running one
    tlb_lookup lookup_probe (
        .entries_i (entries_q),
        .vaddr_i   (probe_vaddr_i),
        .asid_i    (probe_asid_i),
        .result_o  (probe_result_o)
    );

endmodule

`default_nettype wire

// File: hdl/tlb_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// parallel match of one vpn2/asid against all tlb entries
// purely combinational, instantiated per lookup port of the tlb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mmu_defs.svh"

module tlb_lookup
    import mmu_pkg::*;
(
    input  tlb_entry_t  entries_i [`MMU_TLB_ENTRIES],
    input  logic [31:0] vaddr_i,
    input  logic [7:0]  asid_i,
    output tlb_result_t result_o
);

    logic [18:0]                  vpn2;
    logic                         odd;       // va bit 12 picks odd page
    logic [`MMU_TLB_ENTRIES-1:0]  match;
    logic [`MMU_TLB_IDX_W-1:0]    sel;
    tlb_entry_t                   hit_entry;

    assign vpn2 = vaddr_i[31:`MMU_PAGE_SHIFT+1];
    assign odd  = vaddr_i[`MMU_PAGE_SHIFT];

    // compare every entry at once
    always_comb begin
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            match[i] = (entries_i[i].vpn2 == vpn2) &&
                       (entries_i[i].g || (entries_i[i].asid == asid_i));
        end
    end

    // priority encode, walk down so the lowest match wins
    always_comb begin
        sel = '0;
        for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = `MMU_TLB_IDX_W'(i);
            end
        end
    end

    assign hit_entry = entries_i[sel];

    always_comb begin
        result_o.hit = |match;
        result_o.idx = sel;
        if (odd) begin
            result_o.pfn = hit_entry.pfn1;
            result_o.d   = hit_entry.d1;
            result_o.v   = hit_entry.v1;
        end else begin
            result_o.pfn = hit_entry.pfn0;
            result_o.d   = hit_entry.d0;
            result_o.v   = hit_entry.v0;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/mem_map.sv
hdl/tlb_lookup.sv
hdl/tlb_array.sv
hdl/cp0_tlb_regs.sv
hdl/mmu_top.sv
bench/mmu_tb.sv
